//--- verilog/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // Operand and result width.
    localparam int XLEN = 32;

    // Reorder tag width.
    localparam int TAG_W = 4;

    // Issue-order queue depth, three multiplies in flight plus one divide.
    localparam int ORDER_DEPTH = 4;

    typedef enum logic [2:0] {
        MUL   = 3'd0,
        MULH  = 3'd1,
        MULHU = 3'd2,
        DIV   = 3'd3,
        DIVU  = 3'd4,
        REM   = 3'd5,
        REMU  = 3'd6
    } mdu_op_e;

    // Request word, 71 bits.
    typedef struct packed {
        mdu_op_e           op;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   src_a;
        logic [XLEN-1:0]   src_b;
    } mdu_req_t;

    // Result word, 36 bits.
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   data;
    } mdu_res_t;

    // Which unit a queued request went to.
    typedef enum logic {
        UNIT_MUL = 1'b0,
        UNIT_DIV = 1'b1
    } mdu_unit_e;

endpackage

`default_nettype wire

//--- verilog/mdu_muler.sv
`default_nettype none

module mdu_muler import mdu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire logic     flush_i,

    input  wire mdu_req_t req_i,
    input  wire logic     req_valid_i,
    output logic          req_ready_o,

    output mdu_res_t      res_o,
    output logic          res_valid_o,
    input  wire logic     res_ready_i
);

    logic                     s1_valid;
    logic                     s2_valid;
    logic                     s3_valid;
    logic                     s1_en;
    logic                     s2_en;
    logic                     s3_en;
    mdu_op_e                  s1_op;
    mdu_op_e                  s2_op;
    mdu_op_e                  s3_op;
    logic [TAG_W-1:0]         s1_tag;
    logic [TAG_W-1:0]         s2_tag;
    logic [TAG_W-1:0]         s3_tag;
    logic signed [XLEN:0]     s1_a;
    logic signed [XLEN:0]     s1_b;
    (* use_dsp = "yes" *)
    logic signed [2*XLEN+1:0] s2_prod;
    logic signed [2*XLEN+1:0] s3_prod;
    logic                     sign_ext;

    // A stage may load when it is empty or the next stage moves on.
    assign s3_en = !s3_valid || res_ready_i;
    assign s2_en = !s2_valid || s3_en;
    assign s1_en = !s1_valid || s2_en;

    assign req_ready_o = s1_en;

    // MULHU treats both operands as unsigned.
    assign sign_ext = (req_i.op != MULHU);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (flush_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_valid <= req_valid_i;
            end
            if (s2_en) begin
                s2_valid <= s1_valid;
            end
            if (s3_en) begin
                s3_valid <= s2_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_en) begin
            s1_op  <= req_i.op;
            s1_tag <= req_i.tag;
            s1_a   <= {sign_ext & req_i.src_a[XLEN-1], req_i.src_a};
            s1_b   <= {sign_ext & req_i.src_b[XLEN-1], req_i.src_b};
        end
        if (s2_en) begin
            s2_op   <= s1_op;
            s2_tag  <= s1_tag;
            s2_prod <= s1_a * s1_b;
        end
        if (s3_en) begin
            s3_op   <= s2_op;
            s3_tag  <= s2_tag;
            s3_prod <= s2_prod;
        end
    end

    // Low word for MUL, high word for MULH and MULHU.
    always_comb begin
        res_o.tag = s3_tag;
        if (s3_op == MUL) begin
            res_o.data = s3_prod[XLEN-1:0];
        end else begin
            res_o.data = s3_prod[2*XLEN-1:XLEN];
        end
    end

    assign res_valid_o = s3_valid;

endmodule

`default_nettype wire

//--- verilog/mdu_divider.sv
`default_nettype none

module mdu_divider import mdu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire logic     flush_i,

    input  wire mdu_req_t req_i,
    input  wire logic     req_valid_i,
    output logic          req_ready_o,

    output mdu_res_t      res_o,
    output logic          res_valid_o,
    input  wire logic     res_ready_i
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX,
        DONE
    } state_e;

    state_e            state_q;
    logic [4:0]        step_q;
    mdu_op_e           op_q;
    logic [TAG_W-1:0]  tag_q;
    logic [XLEN-1:0]   divisor_q;
    logic [XLEN-1:0]   quo_q;
    logic [XLEN-1:0]   rem_q;
    logic [XLEN-1:0]   data_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              div_zero_q;
    logic              ovf_q;

    logic              is_signed;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [XLEN:0]     shifted;
    logic [XLEN:0]     diff;
    logic [XLEN-1:0]   quo_fix;
    logic [XLEN-1:0]   rem_fix;

    assign is_signed = (req_i.op == DIV) || (req_i.op == REM);
    assign a_neg     = is_signed && req_i.src_a[XLEN-1];
    assign b_neg     = is_signed && req_i.src_b[XLEN-1];
    assign a_mag     = a_neg ? -req_i.src_a : req_i.src_a;
    assign b_mag     = b_neg ? -req_i.src_b : req_i.src_b;

    // One restoring step: shift in the next dividend bit, try the subtract.
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_comb begin
        if (div_zero_q) begin
            quo_fix = '1;
        end else if (ovf_q) begin
            quo_fix = {1'b1, {(XLEN-1){1'b0}}};
        end else begin
            quo_fix = q_neg_q ? -quo_q : quo_q;
        end
        // Remainder keeps the dividend sign, so a zero divisor returns the dividend.
        if (ovf_q) begin
            rem_fix = '0;
        end else begin
            rem_fix = r_neg_q ? -rem_q : rem_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else if (flush_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        state_q <= RUN;
                        step_q  <= '0;
                    end
                end
                RUN: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd31) begin
                        state_q <= FIX;
                    end
                end
                FIX: begin
                    state_q <= DONE;
                end
                DONE: begin
                    if (res_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid_i) begin
            op_q       <= req_i.op;
            tag_q      <= req_i.tag;
            divisor_q  <= b_mag;
            quo_q      <= a_mag;
            rem_q      <= '0;
            q_neg_q    <= a_neg ^ b_neg;
            r_neg_q    <= a_neg;
            div_zero_q <= (req_i.src_b == '0);
            ovf_q      <= is_signed && (req_i.src_a == {1'b1, {(XLEN-1){1'b0}}})
                          && (req_i.src_b == '1);
        end else if (state_q == RUN) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end else if (state_q == FIX) begin
            data_q <= (op_q == DIV || op_q == DIVU) ? quo_fix : rem_fix;
        end
    end

    assign req_ready_o = (state_q == IDLE);
    assign res_valid_o = (state_q == DONE);
    assign res_o.tag   = tag_q;
    assign res_o.data  = data_q;

endmodule

`default_nettype wire

//--- verilog/mdu_sequencer.sv
`default_nettype none

module mdu_sequencer import mdu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire logic     flush_i,

    input  wire mdu_req_t req_i,
    input  wire logic     req_valid_i,
    output logic          req_ready_o,

    output mdu_res_t      res_o,
    output logic          res_valid_o,
    input  wire logic     res_ready_i,

    output mdu_req_t      mul_req_o,
    output logic          mul_req_valid_o,
    input  wire logic     mul_req_ready_i,

    output mdu_req_t      div_req_o,
    output logic          div_req_valid_o,
    input  wire logic     div_req_ready_i,

    input  wire mdu_res_t mul_res_i,
    input  wire logic     mul_res_valid_i,
    output logic          mul_res_ready_o,

    input  wire mdu_res_t div_res_i,
    input  wire logic     div_res_valid_i,
    output logic          div_res_ready_o
);

    localparam int PTR_W = $clog2(ORDER_DEPTH);

    mdu_unit_e         order_q [ORDER_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [PTR_W:0]    count_q;
    logic              q_full;
    logic              q_empty;
    mdu_unit_e         target;
    mdu_unit_e         head;
    logic              push;
    logic              pop;

    assign q_full  = (count_q == (PTR_W+1)'(ORDER_DEPTH));
    assign q_empty = (count_q == '0);

    always_comb begin
        case (req_i.op)
            MUL, MULH, MULHU: target = UNIT_MUL;
            default:          target = UNIT_DIV;
        endcase
    end

    // Request side: steer to the target unit, hold off when the queue is full.
    assign mul_req_o       = req_i;
    assign div_req_o       = req_i;
    assign mul_req_valid_o = req_valid_i && !q_full && (target == UNIT_MUL);
    assign div_req_valid_o = req_valid_i && !q_full && (target == UNIT_DIV);

    always_comb begin
        if (target == UNIT_MUL) begin
            req_ready_o = mul_req_ready_i && !q_full;
        end else begin
            req_ready_o = div_req_ready_i && !q_full;
        end
    end

    assign push = req_valid_i && req_ready_o;

    // Result side: only the unit at the queue head may deliver.
    assign head = order_q[rd_ptr_q];

    always_comb begin
        if (head == UNIT_MUL) begin
            res_o       = mul_res_i;
            res_valid_o = !q_empty && mul_res_valid_i;
        end else begin
            res_o       = div_res_i;
            res_valid_o = !q_empty && div_res_valid_i;
        end
    end

    assign mul_res_ready_o = !q_empty && (head == UNIT_MUL) && res_ready_i;
    assign div_res_ready_o = !q_empty && (head == UNIT_DIV) && res_ready_i;

    assign pop = res_valid_o && res_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + (PTR_W+1)'(1);
                2'b01:   count_q <= count_q - (PTR_W+1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            order_q[wr_ptr_q] <= target;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mdu_unit.sv
`default_nettype none

module mdu_unit import mdu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire logic     flush_i,

    input  wire mdu_req_t req_i,
    input  wire logic     req_valid_i,
    output logic          req_ready_o,

    output mdu_res_t      res_o,
    output logic          res_valid_o,
    input  wire logic     res_ready_i
);

    mdu_req_t  mul_req;
    logic      mul_req_valid;
    logic      mul_req_ready;
    mdu_req_t  div_req;
    logic      div_req_valid;
    logic      div_req_ready;
    mdu_res_t  mul_res;
    logic      mul_res_valid;
    logic      mul_res_ready;
    mdu_res_t  div_res;
    logic      div_res_valid;
    logic      div_res_ready;

    mdu_sequencer u_mdu_sequencer (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .res_o           (res_o),
        .res_valid_o     (res_valid_o),
        .res_ready_i     (res_ready_i),
        .mul_req_o       (mul_req),
        .mul_req_valid_o (mul_req_valid),
        .mul_req_ready_i (mul_req_ready),
        .div_req_o       (div_req),
        .div_req_valid_o (div_req_valid),
        .div_req_ready_i (div_req_ready),
        .mul_res_i       (mul_res),
        .mul_res_valid_i (mul_res_valid),
        .mul_res_ready_o (mul_res_ready),
        .div_res_i       (div_res),
        .div_res_valid_i (div_res_valid),
        .div_res_ready_o (div_res_ready)
    );

    mdu_muler u_mdu_muler (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .req_i       (mul_req),
        .req_valid_i (mul_req_valid),
        .req_ready_o (mul_req_ready),
        .res_o       (mul_res),
        .res_valid_o (mul_res_valid),
        .res_ready_i (mul_res_ready)
    );

    mdu_divider u_mdu_divider (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .req_i       (div_req),
        .req_valid_i (div_req_valid),
        .req_ready_o (div_req_ready),
        .res_o       (div_res),
        .res_valid_o (div_res_valid),
        .res_ready_i (div_res_ready)
    );

endmodule

`default_nettype wire

//--- sim/mdu_unit_assert.sv
`default_nettype none

module mdu_unit_assert import mdu_pkg::*; (
    input wire logic     clk,
    input wire logic     arst_n_i,
    input wire logic     flush_i,
    input wire logic     req_ready_o,
    input wire mdu_res_t res_o,
    input wire logic     res_valid_o,
    input wire logic     res_ready_i
);

    int assert_fails = 0;

    // A stalled result keeps its value until it is taken.
    property res_held_p;
        @(posedge clk) disable iff (!arst_n_i)
        res_valid_o && !res_ready_i && !flush_i |=> res_valid_o && $stable(res_o);
    endproperty

    property ready_after_reset_p;
        @(posedge clk) $rose(arst_n_i) |-> req_ready_o;
    endproperty

    // Flush empties the order queue, so nothing can be offered next cycle.
    property idle_after_flush_p;
        @(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !res_valid_o;
    endproperty

    assert property (res_held_p) else begin
        assert_fails++;
        $error("result changed or dropped while stalled");
    end

    assert property (ready_after_reset_p) else begin
        assert_fails++;
        $error("request ready low after reset");
    end

    assert property (idle_after_flush_p) else begin
        assert_fails++;
        $error("result valid in the cycle after flush");
    end

endmodule

bind mdu_unit mdu_unit_assert u_mdu_unit_assert (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .req_ready_o (req_ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
);

`default_nettype wire

//--- sim/mdu_unit_tb.sv
`default_nettype none

module mdu_unit_tb import mdu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int TIMEOUT    = 200;
    localparam int NUM_RANDOM = 40;
    localparam logic [31:0] SEED = 32'h250d_decd;

    typedef struct packed {
        mdu_op_e         op;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        logic [XLEN-1:0] data;
    } vec_t;

    // The first NUM_MUL_VEC entries are multiplies and the rest are divides.
    localparam int NUM_VEC     = 25;
    localparam int NUM_MUL_VEC = 9;
    localparam vec_t VECS [NUM_VEC] = '{
        '{MUL,   32'd3,         32'd7,         32'h0000_0015},
        '{MUL,   32'hffff_fffe, 32'd5,         32'hffff_fff6},
        '{MUL,   32'h1234_5678, 32'h10,        32'h2345_6780},
        '{MULH,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000},
        '{MULH,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000},
        '{MULH,  32'hffff_fffe, 32'd5,         32'hffff_ffff},
        '{MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe},
        '{MULHU, 32'h8000_0000, 32'd2,         32'h0000_0001},
        '{MULHU, 32'hffff_fffe, 32'd5,         32'h0000_0004},
        '{DIV,   32'd20,        32'd6,         32'h0000_0003},
        '{DIV,   32'hffff_ffec, 32'd6,         32'hffff_fffd},
        '{DIV,   32'd20,        32'hffff_fffa, 32'hffff_fffd},
        '{DIV,   32'hffff_ffec, 32'hffff_fffa, 32'h0000_0003},
        '{DIV,   32'd7,         32'd0,         32'hffff_ffff},
        '{DIV,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000},
        '{DIVU,  32'hffff_ffec, 32'd6,         32'h2aaa_aaa7},
        '{DIVU,  32'd5,         32'd0,         32'hffff_ffff},
        '{REM,   32'd20,        32'd6,         32'h0000_0002},
        '{REM,   32'hffff_ffec, 32'd6,         32'hffff_fffe},
        '{REM,   32'd20,        32'hffff_fffa, 32'h0000_0002},
        '{REM,   32'hffff_ffec, 32'hffff_fffa, 32'hffff_fffe},
        '{REM,   32'hffff_fff9, 32'd0,         32'hffff_fff9},
        '{REM,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000},
        '{REMU,  32'hffff_ffec, 32'd6,         32'h0000_0002},
        '{REMU,  32'd9,         32'd0,         32'h0000_0009}
    };

    logic              clk;
    logic              arst_n_i;
    logic              flush_i;
    mdu_req_t          req_i;
    logic              req_valid_i;
    logic              req_ready_o;
    mdu_res_t          res_o;
    logic              res_valid_o;
    logic              res_ready_i;

    mdu_res_t          expect_q [$];
    mdu_res_t          exp_res;
    logic [2**TAG_W-1:0] stale_tags;
    logic [TAG_W-1:0]  next_tag;
    logic [31:0]       rnd_state;
    logic              bp_mode;
    logic              hold_rdy;
    int                n_err;
    int                n_acc;
    int                n_res;
    int                base_err;
    int                base_acc;
    int                base_res;

    mdu_unit u_mdu_unit (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected result from the RISC-V M rules.
    function automatic logic [XLEN-1:0] ref_result(input mdu_op_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic signed [63:0]     sprod;
        logic [63:0]            uprod;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic [XLEN-1:0]        uq;
        logic [XLEN-1:0]        ur;
        sa    = a;
        sb    = b;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'b0, a} * {32'b0, b};
        if (b == '0) begin
            sq = '1;
            sr = sa;
            uq = '1;
            ur = a;
        end else begin
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                sq = sa;
                sr = '0;
            end else begin
                sq = sa / sb;
                sr = sa % sb;
            end
            uq = a / b;
            ur = a % b;
        end
        case (op)
            MUL:     return sprod[31:0];
            MULH:    return sprod[63:32];
            MULHU:   return uprod[63:32];
            DIV:     return sq;
            DIVU:    return uq;
            REM:     return sr;
            REMU:    return ur;
            default: return '0;
        endcase
    endfunction

    task automatic check_res(input mdu_res_t got, input mdu_res_t exp);
        if (got !== exp) begin
            n_err++;
            $display("** Error: %0t: result tag %0h data %h, expected tag %0h data %h",
                     $time, got.tag, got.data, exp.tag, exp.data);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            n_err++;
            $display("** Error: %0t: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic send_req(input mdu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [XLEN-1:0] data);
        int       waited;
        logic     done;
        mdu_res_t entry;
        waited      = 0;
        done        = 1'b0;
        entry.tag   = next_tag;
        entry.data  = data;
        req_i       = '{op: op, tag: next_tag, src_a: a, src_b: b};
        req_valid_i = 1'b1;
        while (!done && waited < TIMEOUT) begin
            @(negedge clk);
            if (req_ready_o) begin
                expect_q.push_back(entry);
                n_acc++;
                done = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        req_valid_i = 1'b0;
        if (!done) begin
            n_err++;
            $display("Timeout: request with tag %0d was never accepted", next_tag);
        end
        next_tag++;
    endtask

    task automatic send_random();
        mdu_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        rnd_state = lcg_next(rnd_state);
        op        = mdu_op_e'(3'(rnd_state[31:16] % 7));
        rnd_state = lcg_next(rnd_state);
        a         = rnd_state;
        rnd_state = lcg_next(rnd_state);
        b         = rnd_state;
        // Steer some operands into the corner cases.
        case (b[30:28])
            3'd0:    b = '0;
            3'd1:    b = '1;
            3'd2:    b = b >> 24;
            default: b = b;
        endcase
        if (a[30:28] == 3'd0) begin
            a = 32'h8000_0000;
        end
        send_req(op, a, b, ref_result(op, a, b));
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (expect_q.size() != 0) begin
            n_err++;
            $display("Timeout: %0d results never came back", expect_q.size());
            expect_q.delete();
        end
    endtask

    // Returns once a result is being offered at the output.
    task automatic wait_result_offered();
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT) begin
            @(negedge clk);
            seen = res_valid_o;
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (!seen) begin
            n_err++;
            $display("Timeout: no result was offered before the flush");
        end
    endtask

    task automatic end_test(input string name);
        wait_drain();
        check_count("result", n_res - base_res, n_acc - base_acc);
        $display("%-12s %0d requests, %0d results, %0d errors", name,
                 n_acc - base_acc, n_res - base_res, n_err - base_err);
        base_acc = n_acc;
        base_res = n_res;
        base_err = n_err;
    endtask

    // Everything pending is dropped, and its tags must never return.
    task automatic pulse_flush();
        foreach (expect_q[i]) begin
            stale_tags[expect_q[i].tag] = 1'b1;
        end
        expect_q.delete();
        flush_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        flush_i  = 1'b0;
        base_acc = n_acc;
        base_res = n_res;
    endtask

    // Result monitor.
    initial begin
        forever begin
            @(negedge clk);
            if (arst_n_i && !flush_i && res_valid_o && res_ready_i) begin
                n_res++;
                if (stale_tags[res_o.tag]) begin
                    n_err++;
                    $display("Result with tag %0d came back after it was flushed", res_o.tag);
                end else if (expect_q.size() == 0) begin
                    n_err++;
                    $display("Result with tag %0d arrived with no request pending", res_o.tag);
                end else begin
                    exp_res = expect_q.pop_front();
                    check_res(res_o, exp_res);
                end
            end
        end
    end

    // Consumer ready is random under back-pressure and low while held.
    initial begin
        logic [31:0] rdy_state;
        logic        rdy_next;
        rdy_state   = SEED;
        res_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            if (hold_rdy) begin
                rdy_next = 1'b0;
            end else if (bp_mode) begin
                rdy_state = lcg_next(rdy_state);
                rdy_next  = rdy_state[20];
            end else begin
                rdy_next = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DLY;
            res_ready_i = rdy_next;
        end
    end

    initial begin
        arst_n_i    = 1'b0;
        flush_i     = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        bp_mode     = 1'b0;
        hold_rdy    = 1'b0;
        rnd_state   = SEED;
        next_tag    = '0;
        stale_tags  = '0;
        n_err       = 0;
        n_acc       = 0;
        n_res       = 0;
        base_err    = 0;
        base_acc    = 0;
        base_res    = 0;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;

        for (int i = 0; i < NUM_MUL_VEC; i++) begin
            send_req(VECS[i].op, VECS[i].src_a, VECS[i].src_b, VECS[i].data);
        end
        end_test("multiply");

        for (int i = NUM_MUL_VEC; i < NUM_VEC; i++) begin
            send_req(VECS[i].op, VECS[i].src_a, VECS[i].src_b, VECS[i].data);
        end
        end_test("divide");

        // The divide must come back ahead of the multiplies behind it.
        send_req(DIV, 32'hffff_ffec, 32'd6, 32'hffff_fffd);
        send_req(MUL, 32'd3, 32'd7, 32'h0000_0015);
        send_req(MULH, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        send_req(MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        repeat (NUM_RANDOM) send_random();
        end_test("ordering");

        bp_mode = 1'b1;
        repeat (NUM_RANDOM) send_random();
        end_test("backpressure");
        bp_mode = 1'b0;

        // A multiply result sits stalled at the output when the flush hits.
        hold_rdy = 1'b1;
        send_req(MUL, 32'd6, 32'd7, 32'h0000_002a);
        send_req(MULHU, 32'h8000_0000, 32'd2, 32'h0000_0001);
        send_req(DIV, 32'd100, 32'd7, 32'h0000_000e);
        wait_result_offered();
        pulse_flush();
        hold_rdy = 1'b0;
        send_req(MUL, 32'd9, 32'd11, 32'h0000_0063);
        send_req(REM, 32'hffff_ffec, 32'd6, 32'hffff_fffe);
        end_test("flush");

        n_err = n_err + u_mdu_unit.u_mdu_unit_assert.assert_fails;
        $display("%0d requests, %0d results, %0d assertion failures, %0d errors",
                 n_acc, n_res, u_mdu_unit.u_mdu_unit_assert.assert_fails, n_err);
        if (n_err == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mdu_unit.f
verilog/mdu_pkg.sv
verilog/mdu_muler.sv
verilog/mdu_divider.sv
verilog/mdu_sequencer.sv
verilog/mdu_unit.sv
sim/mdu_unit_assert.sv
sim/mdu_unit_tb.sv
